/* frontend.f */
verilog/fe_pkg.sv
verilog/pc_counter.sv
verilog/inst_mem.sv
verilog/skid_ctrl.sv
verilog/skid_regs.sv
verilog/inst_decoder.sv
verilog/frontend_top.sv
dv/tb_frontend.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - files:
      - verilog/fe_pkg.sv
      - verilog/pc_counter.sv
      - verilog/inst_mem.sv
      - verilog/skid_ctrl.sv
      - verilog/skid_regs.sv
      - verilog/inst_decoder.sv
      - verilog/frontend_top.sv
  - target: test
    files:
      - dv/tb_frontend.sv

/* dv/tb_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_frontend;

    // small memory so the streaming test wraps the index
    localparam int DEPTH = 16;
    localparam int IDX_W = $clog2(DEPTH);

    logic                   clk;
    logic                   rst_n;
    logic                   i_run;
    logic                   i_redirect;
    fe_pkg::inst_addr_t     i_redirect_pc;
    logic                   i_mem_we;
    logic [IDX_W-1:0]       i_mem_waddr;
    fe_pkg::inst_data_t     i_mem_wdata;
    logic                   o_fetch_ready;
    logic                   o_dec_valid;
    logic                   i_dec_ready;
    fe_pkg::decode_bundle_t o_dec;

    // reference model state
    fe_pkg::inst_data_t     ref_mem [DEPTH];
    fe_pkg::inst_addr_t     ref_pc;
    fe_pkg::decode_bundle_t exp_q [$];
    int                     cyc_q [$];
    fe_pkg::decode_bundle_t got_q [$];

    logic [31:0] rng;
    string       cur_test;
    int          cycle;
    int          n_ins;
    int          n_tests;
    int          n_checks;
    int          errors;
    logic        lat_check;
    logic        saw_stall;
    logic        timed_out;

    frontend_top #(
        .MEM_DEPTH (DEPTH)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_run         (i_run),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_mem_we      (i_mem_we),
        .i_mem_waddr   (i_mem_waddr),
        .i_mem_wdata   (i_mem_wdata),
        .o_fetch_ready (o_fetch_ready),
        .o_dec_valid   (o_dec_valid),
        .i_dec_ready   (i_dec_ready),
        .o_dec         (o_dec)
    );

    // 100 ns period
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected decode, built from the rv32i format rules
    function automatic fe_pkg::decode_bundle_t ref_decode(input fe_pkg::inst_addr_t pc,
                                                          input fe_pkg::inst_data_t w);
        fe_pkg::decode_bundle_t d;
        logic signed [11:0]     i12;
        logic signed [11:0]     s12;
        logic signed [12:0]     b13;
        logic signed [20:0]     j21;
        i12 = w[31:20];
        s12 = {w[31:25], w[11:7]};
        b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        d.pc     = pc;
        d.opcode = w[6:0];
        d.rd     = w[11:7];
        d.funct3 = w[14:12];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct7 = w[31:25];
        case (w[6:0])
            // load, op-imm, jalr
            7'h03, 7'h13, 7'h67: d.imm = 32'(i12);
            7'h23: d.imm = 32'(s12);
            7'h63: d.imm = 32'(b13);
            // lui, auipc
            7'h37, 7'h17: d.imm = {w[31:12], 12'h000};
            7'h6f: d.imm = 32'(j21);
            default: d.imm = '0;
        endcase
        return d;
    endfunction

    task automatic check_dec(input fe_pkg::decode_bundle_t exp,
                             input fe_pkg::decode_bundle_t act);
        n_checks++;
        if (act !== exp) begin
            errors++;
            $display("Error in %s (decode): expected %h, actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input fe_pkg::inst_addr_t exp,
                              input fe_pkg::inst_addr_t act);
        n_checks++;
        if (act !== exp) begin
            errors++;
            $display("Error in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_imm(input string what, input fe_pkg::imm_t exp,
                             input fe_pkg::imm_t act);
        n_checks++;
        if (act !== exp) begin
            errors++;
            $display("Error in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            errors++;
            $display("Error in %s (%s): expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_int(input string what, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            errors++;
            $display("Error in %s (%s): expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end
        else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // monitor: port level inserts feed the model, transfers are checked
    always @(posedge clk) begin : monitor
        fe_pkg::decode_bundle_t exp_item;
        int                     ins_cyc;
        int                     skid_items;
        if (!rst_n) begin
            ref_pc = fe_pkg::CPU_RESET_ADDR;
        end
        else begin
            // items held in the skid regs, the decoder holds at most one
            skid_items = exp_q.size() - (o_dec_valid ? 1 : 0);
            if (o_dec_valid && i_dec_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: an item was delivered with no insert pending", cur_test);
                end
                else begin
                    exp_item = exp_q.pop_front();
                    ins_cyc  = cyc_q.pop_front();
                    check_dec(exp_item, o_dec);
                    if (lat_check) begin
                        check_int("latency", 2, cycle - ins_cyc);
                    end
                    got_q.push_back(o_dec);
                end
            end
            // memory read happens before this edge's write lands
            if (i_run && o_fetch_ready) begin
                exp_q.push_back(ref_decode(ref_pc, ref_mem[ref_pc[IDX_W+1:2]]));
                cyc_q.push_back(cycle);
                n_ins++;
            end
            if (i_mem_we) begin
                ref_mem[i_mem_waddr] = i_mem_wdata;
            end
            // redirect beats advance
            if (i_redirect) begin
                ref_pc = i_redirect_pc;
            end
            else if (i_run && o_fetch_ready) begin
                ref_pc = ref_pc + 32'd4;
            end
            // ready low only with both skid regs occupied
            check_bit("fetch ready", skid_items != 2, o_fetch_ready);
            check_bit("in flight <= 3", 1'b1, exp_q.size() <= 3);
            if (!o_fetch_ready) begin
                saw_stall = 1'b1;
            end
        end
        cycle++;
    end

    task automatic load_word(input int idx, input fe_pkg::inst_data_t word);
        @(negedge clk);
        i_mem_we    = 1'b1;
        i_mem_waddr = idx[IDX_W-1:0];
        i_mem_wdata = word;
        @(negedge clk);
        i_mem_we    = 1'b0;
    endtask

    task automatic load_random();
        for (int i = 0; i < DEPTH; i++) begin
            rng = xorshift(rng);
            load_word(i, rng);
        end
    endtask

    task automatic pulse_redirect(input fe_pkg::inst_addr_t target);
        @(negedge clk);
        i_redirect    = 1'b1;
        i_redirect_pc = target;
        @(negedge clk);
        i_redirect    = 1'b0;
    endtask

    // every queued item must come out before the limit
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            timed_out = 1'b1;
            $display("%s timed out with %0d items never delivered", cur_test, exp_q.size());
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        got_q.delete();
    endtask

    task automatic end_test(input int err_start);
        n_tests++;
        $display("test %s done, %0d errors", cur_test, errors - err_start);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        start_test("reset");
        check_bit("dec valid", 1'b0, o_dec_valid);
        check_bit("fetch ready", 1'b1, o_fetch_ready);
        check_bit("skid empty", 1'b1, dut0.skid_ctrl0.state == fe_pkg::SKID_EMPTY);
        check_addr("pc", fe_pkg::CPU_RESET_ADDR, dut0.pc_counter0.o_pc);
        load_random();
        // a single fetch
        i_run = 1'b1;
        @(negedge clk);
        i_run = 1'b0;
        wait_drain(20);
        check_int("delivered", 1, got_q.size());
        if (got_q.size() > 0) begin
            check_addr("first pc", fe_pkg::CPU_RESET_ADDR, got_q[0].pc);
        end
        end_test(e0);
    endtask

    task automatic test_stream();
        fe_pkg::inst_addr_t pc0;
        int                 e0;
        int                 ins0;
        e0 = errors;
        ins0 = n_ins;
        start_test("stream");
        load_random();
        i_dec_ready = 1'b1;
        lat_check   = 1'b1;
        @(negedge clk);
        pc0   = ref_pc;
        i_run = 1'b1;
        // long enough to wrap the memory twice
        repeat (2 * DEPTH + 3) @(negedge clk);
        i_run = 1'b0;
        wait_drain(20);
        lat_check = 1'b0;
        check_int("delivered", n_ins - ins0, got_q.size());
        for (int k = 0; k < got_q.size(); k++) begin
            check_addr("pc step", pc0 + 32'(4 * k), got_q[k].pc);
        end
        end_test(e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int ins0;
        e0 = errors;
        ins0 = n_ins;
        start_test("backpressure");
        saw_stall = 1'b0;
        @(negedge clk);
        i_run = 1'b1;
        for (int i = 0; i < 120; i++) begin
            rng = xorshift(rng);
            i_dec_ready = rng[7];
            @(negedge clk);
        end
        i_run       = 1'b0;
        i_dec_ready = 1'b1;
        wait_drain(20);
        check_int("delivered", n_ins - ins0, got_q.size());
        check_bit("ready dropped", 1'b1, saw_stall);
        end_test(e0);
    endtask

    task automatic test_imm_formats();
        fe_pkg::inst_data_t words [7];
        fe_pkg::imm_t       imms [7];
        int                 e0;
        e0 = errors;
        start_test("imm_formats");
        // I, S, B, U (lui), U (auipc), J, unknown opcode
        words = '{32'hFFF1_0093, 32'h8E31_2A23, 32'hFE20_8EE3, 32'h8000_02B7,
                  32'h1234_5297, 32'h8010_00EF, 32'hFFFF_FF7F};
        imms  = '{32'hFFFF_FFFF, 32'hFFFF_F8F4, 32'hFFFF_FFFC, 32'h8000_0000,
                  32'h1234_5000, 32'hFFF0_0800, 32'h0000_0000};
        for (int i = 0; i < 7; i++) begin
            load_word(i, words[i]);
        end
        pulse_redirect(fe_pkg::CPU_RESET_ADDR);
        i_run = 1'b1;
        repeat (7) @(negedge clk);
        i_run = 1'b0;
        wait_drain(20);
        check_int("delivered", 7, got_q.size());
        for (int k = 0; k < 7 && k < got_q.size(); k++) begin
            check_imm($sformatf("imm %0d", k), imms[k], got_q[k].imm);
        end
        end_test(e0);
    endtask

    task automatic test_redirect();
        fe_pkg::inst_addr_t start_pc;
        fe_pkg::inst_addr_t target;
        int                 e0;
        int                 ins0;
        int                 n_before;
        e0 = errors;
        start_test("redirect");
        load_random();
        target = 32'h0000_0124;
        @(negedge clk);
        ins0     = n_ins;
        start_pc = ref_pc;
        i_run    = 1'b1;
        repeat (5) @(negedge clk);
        // redirect while items are in flight
        i_redirect    = 1'b1;
        i_redirect_pc = target;
        @(negedge clk);
        i_redirect = 1'b0;
        n_before   = n_ins - ins0;
        repeat (6) @(negedge clk);
        i_run = 1'b0;
        wait_drain(20);
        check_int("delivered", n_ins - ins0, got_q.size());
        if (got_q.size() >= n_before + 2) begin
            for (int k = 0; k < n_before; k++) begin
                check_addr("old pc", start_pc + 32'(4 * k), got_q[k].pc);
            end
            check_addr("target", target, got_q[n_before].pc);
            check_addr("target + 4", target + 32'd4, got_q[n_before+1].pc);
        end
        end_test(e0);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        i_run         = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_mem_we      = 1'b0;
        i_mem_waddr   = '0;
        i_mem_wdata   = '0;
        i_dec_ready   = 1'b1;
        rng           = 32'd64;
        cycle         = 0;
        n_ins         = 0;
        n_tests       = 0;
        n_checks      = 0;
        errors        = 0;
        lat_check     = 1'b0;
        saw_stall     = 1'b0;
        timed_out     = 1'b0;
        cur_test      = "setup";
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        // a stuck pipeline ends the run early
        if (!timed_out) begin
            test_stream();
        end
        if (!timed_out) begin
            test_backpressure();
        end
        if (!timed_out) begin
            test_imm_formats();
        end
        if (!timed_out) begin
            test_redirect();
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* verilog/frontend_top.sv */
`timescale 1ns/100ps
`default_nettype none

module frontend_top #(
    parameter int MEM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // fetch control
    input  logic                         i_run,
    input  logic                         i_redirect,
    input  fe_pkg::inst_addr_t           i_redirect_pc,

    // memory load port
    input  logic                         i_mem_we,
    input  logic [$clog2(MEM_DEPTH)-1:0] i_mem_waddr,
    input  fe_pkg::inst_data_t           i_mem_wdata,

    output logic                         o_fetch_ready,

    // decode output
    output logic                         o_dec_valid,
    input  logic                         i_dec_ready,
    output fe_pkg::decode_bundle_t       o_dec
);

    fe_pkg::inst_addr_t    pc;
    fe_pkg::inst_data_t    inst;
    fe_pkg::fetch_bundle_t fetch_bundle;
    fe_pkg::fetch_bundle_t skid_bundle;

    logic fetch_valid;
    logic skid_ready;
    logic skid_valid;
    logic insert;
    logic dec_ready;
    logic out_wren;
    logic buf_wren;
    logic use_buf;

    // fetch runs whenever enabled
    assign fetch_valid   = i_run;
    assign insert        = fetch_valid && skid_ready;
    assign o_fetch_ready = skid_ready;

    // pc paired with the word it reads
    always_comb begin
        fetch_bundle.pc   = pc;
        fetch_bundle.inst = inst;
    end

    pc_counter pc_counter0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_advance     (insert),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_pc          (pc)
    );

    inst_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) inst_mem0 (
        .clk     (clk),
        .i_we    (i_mem_we),
        .i_waddr (i_mem_waddr),
        .i_wdata (i_mem_wdata),
        .i_pc    (pc),
        .o_inst  (inst)
    );

    skid_ctrl skid_ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (fetch_valid),
        .o_ready    (skid_ready),
        .o_valid    (skid_valid),
        .i_ready    (dec_ready),
        .o_out_wren (out_wren),
        .o_buf_wren (buf_wren),
        .o_use_buf  (use_buf)
    );

    skid_regs skid_regs0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_out_wren (out_wren),
        .i_buf_wren (buf_wren),
        .i_use_buf  (use_buf),
        .i_data     (fetch_bundle),
        .o_data     (skid_bundle)
    );

    inst_decoder inst_decoder0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (skid_valid),
        .o_ready (dec_ready),
        .i_fetch (skid_bundle),
        .o_valid (o_dec_valid),
        .i_ready (i_dec_ready),
        .o_dec   (o_dec)
    );

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  logic                   clk,
    input  logic                   rst_n,

    // from skid register
    input  logic                   i_valid,
    output logic                   o_ready,
    input  fe_pkg::fetch_bundle_t  i_fetch,

    // to downstream
    output logic                   o_valid,
    input  logic                   i_ready,
    output fe_pkg::decode_bundle_t o_dec
);

    // rv32i base opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    fe_pkg::decode_bundle_t dec;
    logic                   take;

    // immediate by instruction format
    function automatic fe_pkg::imm_t build_imm(input fe_pkg::inst_data_t inst);
        fe_pkg::imm_t imm;
        case (inst[6:0])
            OP_LOAD, OP_IMM, OP_JALR: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            OP_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                // upper 20 bits, low 12 zero
                imm = {inst[31:12], 12'h000};
            end
            OP_JAL: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
        return imm;
    endfunction

    // fixed field positions
    always_comb begin
        dec.pc     = i_fetch.pc;
        dec.opcode = i_fetch.inst[6:0];
        dec.rd     = i_fetch.inst[11:7];
        dec.funct3 = i_fetch.inst[14:12];
        dec.rs1    = i_fetch.inst[19:15];
        dec.rs2    = i_fetch.inst[24:20];
        dec.funct7 = i_fetch.inst[31:25];
        dec.imm    = build_imm(i_fetch.inst);
    end

    // free slot, or current item leaves this cycle
    assign o_ready = !o_valid || i_ready;
    assign take    = i_valid && o_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end
        else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    // output held while stalled
    always_ff @(posedge clk) begin
        if (take) begin
            o_dec <= dec;
        end
    end

endmodule

`default_nettype wire

/* verilog/skid_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module skid_regs (
    input  logic                  clk,
    input  logic                  rst_n,

    // enables from skid_ctrl
    input  logic                  i_out_wren,
    input  logic                  i_buf_wren,
    input  logic                  i_use_buf,

    input  fe_pkg::fetch_bundle_t i_data,
    output fe_pkg::fetch_bundle_t o_data
);

    fe_pkg::fetch_bundle_t buf_q;
    fe_pkg::fetch_bundle_t out_q;
    fe_pkg::fetch_bundle_t sel;
    fe_pkg::fetch_bundle_t nop_bundle;

    // reset contents, a nop at the reset address
    always_comb begin
        nop_bundle.pc   = fe_pkg::CPU_RESET_ADDR;
        nop_bundle.inst = fe_pkg::INST_NOP;
    end

    // buffer reg, written on fill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_q <= nop_bundle;
        end
        else if (i_buf_wren) begin
            buf_q <= i_data;
        end
    end

    // bypass select, buffer only on flush
    assign sel = i_use_buf ? buf_q : i_data;

    // output reg
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= nop_bundle;
        end
        else if (i_out_wren) begin
            out_q <= sel;
        end
    end

    assign o_data = out_q;

endmodule

`default_nettype wire

/* verilog/skid_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module skid_ctrl (
    input  logic clk,
    input  logic rst_n,

    // upstream handshake
    input  logic i_valid,
    output logic o_ready,

    // downstream handshake
    output logic o_valid,
    input  logic i_ready,

    // enables for skid_regs
    output logic o_out_wren,
    output logic o_buf_wren,
    output logic o_use_buf
);

    fe_pkg::skid_state_e state;
    fe_pkg::skid_state_e state_next;

    logic insert;
    logic remove;

    logic load;
    logic flow;
    logic fill;
    logic flush;
    logic unload;

    // transfers on each side
    assign insert = i_valid && o_ready;
    assign remove = o_valid && i_ready;

    // empty datapath takes new item into output reg
    assign load   = (state == fe_pkg::SKID_EMPTY) && insert && !remove;
    // new item replaces the one leaving
    assign flow   = (state == fe_pkg::SKID_BUSY) && insert && remove;
    // output stalled, park new item in buffer
    assign fill   = (state == fe_pkg::SKID_BUSY) && insert && !remove;
    // buffer moves to output, nothing new
    assign flush  = (state == fe_pkg::SKID_FULL) && !insert && remove;
    // last item leaves
    assign unload = (state == fe_pkg::SKID_BUSY) && !insert && remove;

    always_comb begin
        state_next = state;
        if (load || flow || flush) begin
            state_next = fe_pkg::SKID_BUSY;
        end
        else if (fill) begin
            state_next = fe_pkg::SKID_FULL;
        end
        else if (unload) begin
            state_next = fe_pkg::SKID_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fe_pkg::SKID_EMPTY;
        end
        else begin
            state <= state_next;
        end
    end

    // ready and valid registered from next state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_ready <= 1'b1;
            o_valid <= 1'b0;
        end
        else begin
            // drop ready only once the buffer is taken
            o_ready <= (state_next != fe_pkg::SKID_FULL);
            o_valid <= (state_next != fe_pkg::SKID_EMPTY);
        end
    end

    // datapath enables
    assign o_out_wren = load || flow || flush;
    assign o_buf_wren = fill;
    assign o_use_buf  = flush;

endmodule

`default_nettype wire

/* verilog/inst_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_mem #(
    parameter int MEM_DEPTH = 64
) (
    input  logic                         clk,

    // load port, word addressed
    input  logic                         i_we,
    input  logic [$clog2(MEM_DEPTH)-1:0] i_waddr,
    input  fe_pkg::inst_data_t           i_wdata,

    // fetch port, byte addressed
    input  fe_pkg::inst_addr_t           i_pc,
    output fe_pkg::inst_data_t           o_inst
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    fe_pkg::inst_data_t mem [MEM_DEPTH];
    logic [IDX_W-1:0]   ridx;

    // write lands on the edge, seen by the read a cycle later
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // drop the byte offset, wrap modulo depth
    assign ridx = i_pc[IDX_W+1:2];

    // async read at current pc
    assign o_inst = mem[ridx];

endmodule

`default_nettype wire

/* verilog/pc_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_counter (
    input  logic               clk,
    input  logic               rst_n,

    // insert accepted by the skid register
    input  logic               i_advance,

    // branch/jump target from outside
    input  logic               i_redirect,
    input  fe_pkg::inst_addr_t i_redirect_pc,

    output fe_pkg::inst_addr_t o_pc
);

    fe_pkg::inst_addr_t pc;
    fe_pkg::inst_addr_t pc_next;

    // redirect wins over advance
    always_comb begin
        pc_next = pc;
        if (i_redirect) begin
            pc_next = i_redirect_pc;
        end
        else if (i_advance) begin
            // next sequential word
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= fe_pkg::CPU_RESET_ADDR;
        end
        else begin
            pc <= pc_next;
        end
    end

    assign o_pc = pc;

endmodule

`default_nettype wire

/* verilog/fe_pkg.sv */
`default_nettype none

package fe_pkg;

    // byte address of an instruction
    typedef logic [31:0] inst_addr_t;
    // raw instruction word
    typedef logic [31:0] inst_data_t;
    // register index x0..x31
    typedef logic [4:0]  reg_idx_t;
    // sign-extended immediate
    typedef logic [31:0] imm_t;

    // pc and instruction as fetched, 64 bits
    typedef struct packed {
        inst_addr_t pc;
        inst_data_t inst;
    } fetch_bundle_t;

    // decoded instruction fields, 96 bits
    typedef struct packed {
        inst_addr_t pc;
        logic [6:0] opcode;
        reg_idx_t   rd;
        logic [2:0] funct3;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [6:0] funct7;
        imm_t       imm;
    } decode_bundle_t;

    // skid register occupancy
    // only the output reg, or both regs, can hold data
    typedef enum logic [1:0] {
        SKID_EMPTY = 2'd0,
        SKID_BUSY  = 2'd1,
        SKID_FULL  = 2'd2
    } skid_state_e;

    // first fetch address
    localparam inst_addr_t CPU_RESET_ADDR = 32'h0000_0000;
    // addi x0,x0,0
    localparam inst_data_t INST_NOP = 32'h0000_0013;

endpackage

`default_nettype wire
